/* vlog.f */
hw/id_pkg.sv
hw/id_ctrl_if.sv
hw/rv_decoder.sv
hw/operand_path.sv
hw/pc_harden_ctrl.sv
hw/id_ex_pipe.sv
hw/id_stage.sv
sim/tb_clk_gen.sv
sim/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  # RTL in compile order
  - files:
      - hw/id_pkg.sv
      - hw/id_ctrl_if.sv
      - hw/rv_decoder.sv
      - hw/operand_path.sv
      - hw/pc_harden_ctrl.sv
      - hw/id_ex_pipe.sv
      - hw/id_stage.sv
  # Testbench
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_id_stage.sv

/* sim/tb_id_stage.sv */
// Testbench for the RV32I decode stage
// Random instruction stimulus, reference decode model, ID/EX register model
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

  localparam int unsigned RESET_TIMEOUT = 50;
  localparam int unsigned DRAIN_TIMEOUT = 20;
  localparam int unsigned PHASES        = 6;
  localparam int unsigned PHASE_CYCLES  = 150;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic [31:0] instr_i;
  logic [31:0] pc_i;
  logic        instr_valid_i;
  logic        kill_i;
  logic        halt_i;
  logic        ex_ready_i;
  logic        pc_hardening_i;
  fw_sel_e     fw_a_sel_i;
  fw_sel_e     fw_b_sel_i;
  logic [31:0] rf_rdata_a_i;
  logic [31:0] rf_rdata_b_i;
  logic [31:0] rf_wdata_ex_i;
  logic [31:0] rf_wdata_wb_i;

  // DUT outputs
  rf_addr_t    rf_raddr_a_o;
  rf_addr_t    rf_raddr_b_o;
  logic [31:0] jmp_target_o;
  logic        id_ready_o;
  logic        ex_valid_o;
  logic        ex_alu_en_o;
  logic        ex_alu_bch_o;
  logic        ex_alu_jmp_o;
  logic        ex_rf_we_o;
  logic        ex_illegal_o;
  logic        ex_last_op_o;
  alu_op_e     ex_alu_op_o;
  logic [31:0] ex_operand_a_o;
  logic [31:0] ex_operand_b_o;
  logic [31:0] ex_operand_c_o;
  rf_addr_t    ex_rf_waddr_o;

  integer      seed;
  int unsigned errors;
  logic        consumed;
  int unsigned op_cnt;

  // Decode of the instruction currently in ID
  logic        m_alu_en;
  logic        m_bch;
  logic        m_jmp;
  logic        m_rf_we;
  logic        m_illegal;
  logic        m_use_a;
  logic        m_use_b;
  logic        m_use_c;
  alu_op_e     m_op;
  logic [31:0] m_a;
  logic [31:0] m_b;
  logic [31:0] m_c;
  logic [31:0] m_target;

  // Expected ID/EX register contents
  logic        e_valid;
  logic        e_alu_en;
  logic        e_bch;
  logic        e_jmp;
  logic        e_rf_we;
  logic        e_illegal;
  logic        e_last;
  alu_op_e     e_op;
  logic [31:0] e_a;
  logic [31:0] e_b;
  logic [31:0] e_c;
  logic [4:0]  e_rd;

  tb_clk_gen i_tb_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  id_stage i_id_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .instr_valid_i  (instr_valid_i),
    .kill_i         (kill_i),
    .halt_i         (halt_i),
    .ex_ready_i     (ex_ready_i),
    .pc_hardening_i (pc_hardening_i),
    .fw_a_sel_i     (fw_a_sel_i),
    .fw_b_sel_i     (fw_b_sel_i),
    .rf_rdata_a_i   (rf_rdata_a_i),
    .rf_rdata_b_i   (rf_rdata_b_i),
    .rf_wdata_ex_i  (rf_wdata_ex_i),
    .rf_wdata_wb_i  (rf_wdata_wb_i),
    .rf_raddr_a_o   (rf_raddr_a_o),
    .rf_raddr_b_o   (rf_raddr_b_o),
    .jmp_target_o   (jmp_target_o),
    .id_ready_o     (id_ready_o),
    .ex_valid_o     (ex_valid_o),
    .ex_alu_en_o    (ex_alu_en_o),
    .ex_alu_bch_o   (ex_alu_bch_o),
    .ex_alu_jmp_o   (ex_alu_jmp_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_illegal_o   (ex_illegal_o),
    .ex_last_op_o   (ex_last_op_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_operand_c_o (ex_operand_c_o),
    .ex_rf_waddr_o  (ex_rf_waddr_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("Error %s at %0t: got 0x%h, expected 0x%h", name, $time, act, exp);
      errors++;
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  // Mostly legal words of the kept groups, some arbitrary words
  function automatic logic [31:0] rand_instr();
    logic [31:0] w;
    logic [6:0]  f7;
    w  = $random(seed);
    f7 = (rand_below(4) == 0) ? w[31:25] : ((rand_below(2) == 0) ? 7'h20 : 7'h00);
    case (rand_below(8))
      0:       w = {f7, w[24:7], 7'b0110011};
      1:       w = {f7, w[24:7], 7'b0010011};
      2:       w[6:0] = 7'b0110111;
      3:       w[6:0] = 7'b0010111;
      4:       w[6:0] = 7'b1101111;
      5:       w[6:0] = 7'b1100111;
      6:       w[6:0] = 7'b1100011;
      default: w = w;
    endcase
    return w;
  endfunction

  // RV32I funct3 table, alt picks SUB or SRA
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? SUB : ADD;
      3'd1:    return SLL;
      3'd2:    return SLT;
      3'd3:    return SLTU;
      3'd4:    return XOR;
      3'd5:    return alt ? SRA : SRL;
      3'd6:    return OR;
      default: return AND;
    endcase
  endfunction

  function automatic logic [31:0] pick_fw(input fw_sel_e sel, input logic [31:0] rf);
    case (sel)
      FW_EX:   return rf_wdata_ex_i;
      FW_WB:   return rf_wdata_wb_i;
      default: return rf;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference decode
  ////////////////////////////////////////////////////////////////////////////

  task automatic predict_decode();
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        f7_ok;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    f3    = instr_i[14:12];
    f7    = instr_i[31:25];
    f7_ok = (f7 == 7'h00) || (f7 == 7'h20);
    ra    = pick_fw(fw_a_sel_i, rf_rdata_a_i);
    rb    = pick_fw(fw_b_sel_i, rf_rdata_b_i);
    imm_i = 32'($signed(instr_i[31:20]));
    imm_u = instr_i & 32'hffff_f000;
    imm_b = 32'($signed({instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0}));
    imm_j = 32'($signed({instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0}));
    // Immediate ALU op writing rd unless the group says otherwise
    m_illegal = 1'b0;
    m_alu_en  = 1'b1;
    m_op      = ADD;
    m_bch     = 1'b0;
    m_jmp     = 1'b0;
    m_rf_we   = 1'b1;
    m_use_a   = 1'b1;
    m_use_b   = 1'b1;
    m_use_c   = 1'b0;
    m_a       = ra;
    m_b       = imm_i;
    m_c       = rb;
    m_target  = pc_i + imm_j;
    case (instr_i[6:0])
      7'b0110011: begin
        m_b       = rb;
        m_use_c   = 1'b1;
        m_op      = alu_from_funct3(f3, f7[5]);
        m_illegal = !f7_ok;
      end
      7'b0010011: begin
        m_op = alu_from_funct3(f3, f7[5] && (f3 == 3'd5));
        if ((f3 == 3'd1) || (f3 == 3'd5)) begin
          m_illegal = !f7_ok;
        end
      end
      7'b0110111: begin
        m_a = '0;
        m_b = imm_u;
      end
      7'b0010111: begin
        m_a = pc_i;
        m_b = imm_u;
      end
      7'b1101111, 7'b1100111: begin
        // Link address pc + 4 goes through the ALU
        m_a   = pc_i;
        m_b   = 32'd4;
        m_jmp = 1'b1;
        if (instr_i[3] == 1'b0) begin
          m_target = (ra + imm_i) & ~32'd1;
        end
      end
      7'b1100011: begin
        m_bch   = 1'b1;
        m_b     = rb;
        m_c     = pc_i + imm_b;
        m_use_c = 1'b1;
        m_rf_we = 1'b0;
        case (f3)
          3'd0:    m_op = EQ;
          3'd1:    m_op = NE;
          3'd4:    m_op = LT;
          3'd5:    m_op = GE;
          3'd6:    m_op = LTU;
          3'd7:    m_op = GEU;
          default: m_illegal = 1'b1;
        endcase
      end
      default: m_illegal = 1'b1;
    endcase
    if (m_illegal) begin
      m_alu_en = 1'b0;
      m_rf_we  = 1'b0;
      m_bch    = 1'b0;
      m_jmp    = 1'b0;
      m_use_a  = 1'b0;
      m_use_b  = 1'b0;
      m_use_c  = 1'b0;
    end
  endtask

  task automatic check_ex_outputs();
    check_val("ex_valid_o", ex_valid_o, e_valid);
    check_val("ex_alu_en_o", ex_alu_en_o, e_alu_en);
    check_val("ex_alu_bch_o", ex_alu_bch_o, e_bch);
    check_val("ex_alu_jmp_o", ex_alu_jmp_o, e_jmp);
    check_val("ex_rf_we_o", ex_rf_we_o, e_rf_we);
    check_val("ex_illegal_o", ex_illegal_o, e_illegal);
    check_val("ex_last_op_o", ex_last_op_o, e_last);
    check_val("ex_alu_op_o", ex_alu_op_o, e_op);
    check_val("ex_operand_a_o", ex_operand_a_o, e_a);
    check_val("ex_operand_b_o", ex_operand_b_o, e_b);
    check_val("ex_operand_c_o", ex_operand_c_o, e_c);
    check_val("ex_rf_waddr_o", ex_rf_waddr_o, e_rd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One clock cycle, entered and left on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic step_cycle(input logic force_kill);
    logic last_op;
    logic id_valid;
    logic ready;
    check_ex_outputs();
    // A pending instruction holds all of its inputs
    if (consumed) begin
      instr_i       = rand_instr();
      pc_i          = $random(seed) & ~32'd3;
      rf_rdata_a_i  = $random(seed);
      rf_rdata_b_i  = $random(seed);
      rf_wdata_ex_i = $random(seed);
      rf_wdata_wb_i = $random(seed);
      fw_a_sel_i    = fw_sel_e'(rand_below(3));
      fw_b_sel_i    = fw_sel_e'(rand_below(3));
      instr_valid_i = (rand_below(10) != 0);
    end
    ex_ready_i = (rand_below(5) != 0);
    kill_i     = force_kill || (rand_below(25) == 0);
    halt_i     = (rand_below(20) == 0);
    #1;
    predict_decode();
    check_val("rf_raddr_a_o", rf_raddr_a_o, instr_i[19:15]);
    check_val("rf_raddr_b_o", rf_raddr_b_o, instr_i[24:20]);
    if (m_jmp) begin
      check_val("jmp_target_o", jmp_target_o, m_target);
    end
    // Only the first operation of a hardened jump or branch is not the last
    if (m_alu_en && (m_jmp || m_bch) && pc_hardening_i && (op_cnt == 0)) begin
      last_op = 1'b0;
    end else begin
      last_op = 1'b1;
    end
    id_valid = instr_valid_i && !kill_i && !halt_i;
    // Kill flushes ID while halt and back-pressure hold it
    if (kill_i) begin
      ready = 1'b1;
    end else if (halt_i || !ex_ready_i) begin
      ready = 1'b0;
    end else begin
      ready = !instr_valid_i || last_op;
    end
    check_val("id_ready_o", id_ready_o, ready);
    consumed = !instr_valid_i || ready;
    if (kill_i) begin
      op_cnt = 0;
    end else if (id_valid && ex_ready_i) begin
      op_cnt = last_op ? 0 : op_cnt + 1;
    end
    // Register update at the coming rising edge
    if (id_valid && ex_ready_i) begin
      e_valid   = 1'b1;
      e_last    = last_op;
      e_alu_en  = m_alu_en;
      e_rf_we   = m_rf_we;
      e_illegal = m_illegal;
      if (m_use_a) begin
        e_a = m_a;
      end
      if (m_use_b) begin
        e_b = m_b;
      end
      if (m_use_c) begin
        e_c = m_c;
      end
      if (m_alu_en) begin
        e_op  = m_op;
        e_bch = m_bch;
        e_jmp = m_jmp;
      end
      if (m_rf_we) begin
        e_rd = instr_i[11:7];
      end
    end else if (ex_ready_i) begin
      e_valid = 1'b0;
    end
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned waited;
    seed           = 32'hd934_2683;
    errors         = 0;
    consumed       = 1'b1;
    op_cnt         = 0;
    instr_i        = '0;
    pc_i           = '0;
    instr_valid_i  = 1'b0;
    kill_i         = 1'b0;
    halt_i         = 1'b0;
    ex_ready_i     = 1'b0;
    pc_hardening_i = 1'b0;
    fw_a_sel_i     = FW_RF;
    fw_b_sel_i     = FW_RF;
    rf_rdata_a_i   = '0;
    rf_rdata_b_i   = '0;
    rf_wdata_ex_i  = '0;
    rf_wdata_wb_i  = '0;
    // Reset contents of the ID/EX register
    {e_valid, e_alu_en, e_bch, e_jmp, e_rf_we, e_illegal, e_last} = '0;
    e_op = SLTU;
    e_a  = '0;
    e_b  = '0;
    e_c  = '0;
    e_rd = '0;

    waited = 0;
    while ((rst_n !== 1'b1) && (waited < RESET_TIMEOUT)) begin
      @(negedge clk);
      waited++;
    end

    if (rst_n !== 1'b1) begin
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
      errors++;
    end else begin
      for (int unsigned phase = 0; phase < PHASES; phase++) begin
        // First two phases cover both modes, later ones are random
        pc_hardening_i = (phase < 2) ? phase[0] : rand_below(2);
        step_cycle(1'b1);
        repeat (PHASE_CYCLES) step_cycle(1'b0);
      end
      // Drain, EX stays ready with nothing new
      instr_valid_i = 1'b0;
      kill_i        = 1'b0;
      halt_i        = 1'b0;
      ex_ready_i    = 1'b1;
      waited        = 0;
      while (ex_valid_o && (waited < DRAIN_TIMEOUT)) begin
        @(negedge clk);
        waited++;
      end
      if (ex_valid_o) begin
        $display("ex_valid_o stayed high after the stage was drained");
        errors++;
      end
    end

    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* sim/tb_clk_gen.sv */
// Testbench clock and reset source
// 10 ns clock, active low reset held for the first cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int unsigned HALF_PERIOD  = 5;
  localparam int unsigned RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Release on a falling edge, away from the flop updates
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* hw/id_stage.sv */
// Decode stage top level
// Decoder, operand path, hardening control and ID/EX register
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            instr_valid_i,
  input  logic            kill_i,
  input  logic            halt_i,
  input  logic            ex_ready_i,
  input  logic            pc_hardening_i,
  input  fw_sel_e         fw_a_sel_i,
  input  fw_sel_e         fw_b_sel_i,
  input  logic [XLEN-1:0] rf_rdata_a_i,
  input  logic [XLEN-1:0] rf_rdata_b_i,
  input  logic [XLEN-1:0] rf_wdata_ex_i,
  input  logic [XLEN-1:0] rf_wdata_wb_i,
  output rf_addr_t        rf_raddr_a_o,
  output rf_addr_t        rf_raddr_b_o,
  output logic [XLEN-1:0] jmp_target_o,
  output logic            id_ready_o,
  output logic            ex_valid_o,
  output logic            ex_alu_en_o,
  output logic            ex_alu_bch_o,
  output logic            ex_alu_jmp_o,
  output logic            ex_rf_we_o,
  output logic            ex_illegal_o,
  output logic            ex_last_op_o,
  output alu_op_e         ex_alu_op_o,
  output logic [XLEN-1:0] ex_operand_a_o,
  output logic [XLEN-1:0] ex_operand_b_o,
  output logic [XLEN-1:0] ex_operand_c_o,
  output rf_addr_t        ex_rf_waddr_o
);

  logic            id_valid;
  logic            last_op;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] operand_c;
  rf_addr_t        rf_waddr;

  // Decoded control shared inside the stage
  id_ctrl_if ctrl_if ();

  rv_decoder i_rv_decoder (
    .instr_i (instr_i),
    .ctrl    (ctrl_if.dec)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Operands and targets, combinational in ID
  ////////////////////////////////////////////////////////////////////////////

  operand_path i_operand_path (
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .fw_a_sel_i    (fw_a_sel_i),
    .fw_b_sel_i    (fw_b_sel_i),
    .ctrl          (ctrl_if.user),
    .rf_raddr_a_o  (rf_raddr_a_o),
    .rf_raddr_b_o  (rf_raddr_b_o),
    .rf_waddr_o    (rf_waddr),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c),
    .jmp_target_o  (jmp_target_o)
  );

  // Stage handshake and multi-operation count
  pc_harden_ctrl i_pc_harden_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .kill_i         (kill_i),
    .halt_i         (halt_i),
    .ex_ready_i     (ex_ready_i),
    .pc_hardening_i (pc_hardening_i),
    .ctrl           (ctrl_if.user),
    .id_valid_o     (id_valid),
    .id_ready_o     (id_ready_o),
    .last_op_o      (last_op)
  );

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////////////

  id_ex_pipe i_id_ex_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_valid_i     (id_valid),
    .ex_ready_i     (ex_ready_i),
    .last_op_i      (last_op),
    .ctrl           (ctrl_if.user),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .operand_c_i    (operand_c),
    .rf_waddr_i     (rf_waddr),
    .ex_valid_o     (ex_valid_o),
    .ex_alu_en_o    (ex_alu_en_o),
    .ex_alu_bch_o   (ex_alu_bch_o),
    .ex_alu_jmp_o   (ex_alu_jmp_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_illegal_o   (ex_illegal_o),
    .ex_last_op_o   (ex_last_op_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_operand_c_o (ex_operand_c_o),
    .ex_rf_waddr_o  (ex_rf_waddr_o)
  );

endmodule

/* hw/id_ex_pipe.sv */
// ID/EX pipeline register
// Enables captured on every transfer, payload only where used
`timescale 1ns/1ps

module id_ex_pipe import id_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            id_valid_i,
  input  logic            ex_ready_i,
  input  logic            last_op_i,
  id_ctrl_if.user         ctrl,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  input  logic [XLEN-1:0] operand_c_i,
  input  rf_addr_t        rf_waddr_i,
  output logic            ex_valid_o,
  output logic            ex_alu_en_o,
  output logic            ex_alu_bch_o,
  output logic            ex_alu_jmp_o,
  output logic            ex_rf_we_o,
  output logic            ex_illegal_o,
  output logic            ex_last_op_o,
  output alu_op_e         ex_alu_op_o,
  output logic [XLEN-1:0] ex_operand_a_o,
  output logic [XLEN-1:0] ex_operand_b_o,
  output logic [XLEN-1:0] ex_operand_c_o,
  output rf_addr_t        ex_rf_waddr_o
);

  logic transfer;

  assign transfer = id_valid_i && ex_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o     <= 1'b0;
      ex_alu_en_o    <= 1'b0;
      ex_alu_bch_o   <= 1'b0;
      ex_alu_jmp_o   <= 1'b0;
      ex_rf_we_o     <= 1'b0;
      ex_illegal_o   <= 1'b0;
      ex_last_op_o   <= 1'b0;
      ex_alu_op_o    <= SLTU;
      ex_operand_a_o <= '0;
      ex_operand_b_o <= '0;
      ex_operand_c_o <= '0;
      ex_rf_waddr_o  <= '0;
    end else if (transfer) begin
      // Enables and status, always
      ex_valid_o   <= 1'b1;
      ex_last_op_o <= last_op_i;
      ex_alu_en_o  <= ctrl.alu_en;
      ex_rf_we_o   <= ctrl.rf_we;
      ex_illegal_o <= ctrl.illegal;

      // Unused operands keep their old value
      if (ctrl.op_a_sel != OPA_NONE) begin
        ex_operand_a_o <= operand_a_i;
      end
      if (ctrl.op_b_sel != OPB_NONE) begin
        ex_operand_b_o <= operand_b_i;
      end
      if (ctrl.op_c_sel != OPC_SEL_NONE) begin
        ex_operand_c_o <= operand_c_i;
      end

      // ALU payload only for ALU instructions
      if (ctrl.alu_en) begin
        ex_alu_op_o  <= ctrl.alu_op;
        ex_alu_bch_o <= ctrl.alu_bch;
        ex_alu_jmp_o <= ctrl.alu_jmp;
      end

      if (ctrl.rf_we) begin
        ex_rf_waddr_o <= rf_waddr_i;
      end
    end else if (ex_ready_i) begin
      // EX consumed its instruction, nothing new
      ex_valid_o <= 1'b0;
    end
  end

endmodule

/* hw/pc_harden_ctrl.sv */
// Operation counter for hardened jumps and branches
// Stage ready/valid generation with kill and halt
`timescale 1ns/1ps

module pc_harden_ctrl import id_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    instr_valid_i,
  input  logic    kill_i,
  input  logic    halt_i,
  input  logic    ex_ready_i,
  input  logic    pc_hardening_i,
  id_ctrl_if.user ctrl,
  output logic    id_valid_o,
  output logic    id_ready_o,
  output logic    last_op_o
);

  logic                      jmp_bch_insn;
  logic                      multi_op_stall;
  logic [MULTI_OP_CNT_W-1:0] multi_op_cnt;

  // Jumps and branches that reach the ALU
  assign jmp_bch_insn = ctrl.alu_en && (ctrl.alu_jmp || ctrl.alu_bch);

  // Single operation unless hardening splits the instruction
  assign last_op_o = (jmp_bch_insn && pc_hardening_i) ?
                     (multi_op_cnt == MULTI_OP_CNT_W'(JMP_BCH_CYCLES - 1)) : 1'b1;

  // Hold the instruction in ID until its last operation
  assign multi_op_stall = instr_valid_i && !last_op_o;

  // Kill flushes ID, halt freezes it
  assign id_ready_o = kill_i || (!multi_op_stall && ex_ready_i && !halt_i);

  // Valid stays up during the stall so EX sees each operation
  assign id_valid_o = instr_valid_i && !kill_i && !halt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      multi_op_cnt <= '0;
    end else if (kill_i) begin
      multi_op_cnt <= '0;
    end else if (id_valid_o && ex_ready_i) begin
      // Wrap after the last operation
      multi_op_cnt <= last_op_o ? '0 : multi_op_cnt + 1'b1;
    end
  end

  a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
    multi_op_cnt <= MULTI_OP_CNT_W'(JMP_BCH_CYCLES - 1));

  // A new instruction is only accepted once the current one is finished
  a_ready_on_last: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_i && !kill_i && id_ready_o) |-> last_op_o);

endmodule

/* hw/operand_path.sv */
// Immediate extraction, forwarding muxes, operand A/B/C selection
// Branch and jump target adders
`timescale 1ns/1ps

module operand_path import id_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rf_rdata_a_i,
  input  logic [XLEN-1:0] rf_rdata_b_i,
  input  logic [XLEN-1:0] rf_wdata_ex_i,
  input  logic [XLEN-1:0] rf_wdata_wb_i,
  input  fw_sel_e         fw_a_sel_i,
  input  fw_sel_e         fw_b_sel_i,
  id_ctrl_if.user         ctrl,
  output rf_addr_t        rf_raddr_a_o,
  output rf_addr_t        rf_raddr_b_o,
  output rf_addr_t        rf_waddr_o,
  output logic [XLEN-1:0] operand_a_o,
  output logic [XLEN-1:0] operand_b_o,
  output logic [XLEN-1:0] operand_c_o,
  output logic [XLEN-1:0] jmp_target_o
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] operand_a_fw;
  logic [XLEN-1:0] operand_b_fw;
  logic [XLEN-1:0] bch_target;
  logic [XLEN-1:0] jalr_sum;

  // Newest value wins, register file last
  function automatic logic [XLEN-1:0] fw_mux(
    input fw_sel_e         sel,
    input logic [XLEN-1:0] rf,
    input logic [XLEN-1:0] ex,
    input logic [XLEN-1:0] wb
  );
    case (sel)
      FW_EX:   fw_mux = ex;
      FW_WB:   fw_mux = wb;
      default: fw_mux = rf;
    endcase
  endfunction

  // Register addresses straight from the instruction word
  assign rf_raddr_a_o = instr_i[RS1_MSB:RS1_LSB];
  assign rf_raddr_b_o = instr_i[RS2_MSB:RS2_LSB];
  assign rf_waddr_o   = instr_i[RD_MSB:RD_LSB];

  ////////////////////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////////////////////

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // B and J immediates only feed the target adders
  assign imm = (ctrl.imm_sel == IMM_U) ? imm_u : imm_i;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding and operand muxes
  ////////////////////////////////////////////////////////////////////////////

  assign operand_a_fw = fw_mux(fw_a_sel_i, rf_rdata_a_i, rf_wdata_ex_i, rf_wdata_wb_i);
  assign operand_b_fw = fw_mux(fw_b_sel_i, rf_rdata_b_i, rf_wdata_ex_i, rf_wdata_wb_i);

  always_comb begin
    case (ctrl.op_a_sel)
      OPA_PC:   operand_a_o = pc_i;
      OPA_ZERO: operand_a_o = '0;
      default:  operand_a_o = operand_a_fw;
    endcase
  end

  always_comb begin
    case (ctrl.op_b_sel)
      OPB_IMM:    operand_b_o = imm;
      OPB_PCINCR: operand_b_o = PC_INCR;
      default:    operand_b_o = operand_b_fw;
    endcase
  end

  // Operand C holds rs2 or the branch target
  assign operand_c_o = (ctrl.op_c_sel == OPC_SEL_BCH) ? bch_target : operand_b_fw;

  ////////////////////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////////////////////

  assign bch_target = pc_i + imm_b;
  assign jalr_sum   = operand_a_fw + imm_i;

  // JALR clears bit 0 of rs1 + imm
  assign jmp_target_o = ctrl.alu_jmpr ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_j;

endmodule

/* hw/rv_decoder.sv */
// RV32I opcode and funct decoder for OP, OP-IMM, LUI, AUIPC, JAL, JALR, BRANCH
`timescale 1ns/1ps

module rv_decoder import id_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  id_ctrl_if.dec          ctrl
);

  logic [OPCODE_W-1:0] opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                funct7_ok;
  logic                illegal;

  // Shared by register and immediate arithmetic
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? SUB : ADD;
      3'b001:  arith_op = SLL;
      3'b010:  arith_op = SLT;
      3'b011:  arith_op = SLTU;
      3'b100:  arith_op = XOR;
      3'b101:  arith_op = alt ? SRA : SRL;
      3'b110:  arith_op = OR;
      default: arith_op = AND;
    endcase
  endfunction

  assign opcode = instr_i[OPCODE_W-1:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Base or alternate (SUB/SRA) encoding only
  assign funct7_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

  always_comb begin
    // Defaults fit an immediate ALU op writing rd
    illegal       = 1'b0;
    ctrl.alu_en   = 1'b1;
    ctrl.alu_op   = ADD;
    ctrl.alu_bch  = 1'b0;
    ctrl.alu_jmp  = 1'b0;
    ctrl.alu_jmpr = 1'b0;
    ctrl.op_a_sel = OPA_REG;
    ctrl.op_b_sel = OPB_IMM;
    ctrl.op_c_sel = OPC_SEL_NONE;
    ctrl.imm_sel  = IMM_I;
    ctrl.rf_we    = 1'b1;

    case (opcode)
      OPC_OP: begin
        ctrl.op_b_sel = OPB_REG;
        ctrl.op_c_sel = OPC_SEL_REG;
        ctrl.alu_op   = arith_op(funct3, funct7[5]);
        illegal       = !funct7_ok;
      end
      OPC_OPIMM: begin
        // Only the shift immediates carry a funct7 field
        ctrl.alu_op = arith_op(funct3, funct7[5] && (funct3 == 3'b101));
        if ((funct3 == 3'b001) || (funct3 == 3'b101)) begin
          illegal = !funct7_ok;
        end
      end
      OPC_LUI: begin
        ctrl.op_a_sel = OPA_ZERO;
        ctrl.imm_sel  = IMM_U;
      end
      OPC_AUIPC: begin
        ctrl.op_a_sel = OPA_PC;
        ctrl.imm_sel  = IMM_U;
      end
      OPC_JAL, OPC_JALR: begin
        // ALU computes the link address pc + 4
        ctrl.alu_jmp  = 1'b1;
        ctrl.alu_jmpr = (opcode == OPC_JALR);
        ctrl.op_a_sel = OPA_PC;
        ctrl.op_b_sel = OPB_PCINCR;
      end
      OPC_BRANCH: begin
        // Compare in the ALU, target travels on operand C
        ctrl.alu_bch  = 1'b1;
        ctrl.op_b_sel = OPB_REG;
        ctrl.op_c_sel = OPC_SEL_BCH;
        ctrl.rf_we    = 1'b0;
        case (funct3)
          3'b000:  ctrl.alu_op = EQ;
          3'b001:  ctrl.alu_op = NE;
          3'b100:  ctrl.alu_op = LT;
          3'b101:  ctrl.alu_op = GE;
          3'b110:  ctrl.alu_op = LTU;
          3'b111:  ctrl.alu_op = GEU;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase

    // Illegal word leaves EX and the register file untouched
    if (illegal) begin
      ctrl.alu_en   = 1'b0;
      ctrl.alu_bch  = 1'b0;
      ctrl.alu_jmp  = 1'b0;
      ctrl.alu_jmpr = 1'b0;
      ctrl.rf_we    = 1'b0;
      ctrl.op_a_sel = OPA_NONE;
      ctrl.op_b_sel = OPB_NONE;
      ctrl.op_c_sel = OPC_SEL_NONE;
    end
    ctrl.illegal = illegal;
  end

  // An illegal instruction never reaches the ALU or the register file
  a_illegal_no_write: assert final (!ctrl.illegal || (!ctrl.rf_we && !ctrl.alu_en));

endmodule

/* hw/id_ctrl_if.sv */
// Decoded control bundle between the decoder and the rest of the decode stage
`timescale 1ns/1ps

interface id_ctrl_if import id_pkg::*; ();

  // ALU enable and operation
  logic      alu_en;
  alu_op_e   alu_op;

  // Control flow flags
  logic      alu_bch;
  logic      alu_jmp;
  logic      alu_jmpr;

  // Operand and immediate selects
  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  op_c_sel_e op_c_sel;
  imm_sel_e  imm_sel;

  logic      rf_we;
  logic      illegal;

  // Decoder side
  modport dec (
    output alu_en, alu_op, alu_bch, alu_jmp, alu_jmpr,
    output op_a_sel, op_b_sel, op_c_sel, imm_sel, rf_we, illegal
  );

  // Consumers in the stage
  modport user (
    input alu_en, alu_op, alu_bch, alu_jmp, alu_jmpr,
    input op_a_sel, op_b_sel, op_c_sel, imm_sel, rf_we, illegal
  );

endinterface

/* hw/id_pkg.sv */
// Shared definitions for the RV32I decode stage
// Field positions, widths, opcode and select encodings, hardening constants
package id_pkg;

  // Datapath and register file widths
  localparam int unsigned XLEN      = 32;
  localparam int unsigned RF_ADDR_W = 5;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  // Register index positions inside the instruction word
  localparam int unsigned RS1_MSB = 19;
  localparam int unsigned RS1_LSB = 15;
  localparam int unsigned RS2_MSB = 24;
  localparam int unsigned RS2_LSB = 20;
  localparam int unsigned RD_MSB  = 11;
  localparam int unsigned RD_LSB  = 7;

  localparam int unsigned OPCODE_W = 7;

  // Link increment, no compressed instructions
  localparam logic [XLEN-1:0] PC_INCR = 32'd4;

  // Hardened jumps and branches run as two operations
  localparam int unsigned JMP_BCH_CYCLES = 2;
  localparam int unsigned MULTI_OP_CNT_W = 1;

  // Major opcodes of the supported groups
  typedef enum logic [OPCODE_W-1:0] {
    OPC_OP     = 7'b0110011,
    OPC_OPIMM  = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // Arithmetic, logic, shift and branch compare operations
  typedef enum logic [3:0] {
    ADD, SUB, XOR, OR,
    AND, SLL, SRL, SRA,
    SLT, SLTU, EQ, NE,
    LT, GE, LTU, GEU
  } alu_op_e;

  // Operand select encodings
  typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO, OPA_NONE} op_a_sel_e;
  typedef enum logic [1:0] {OPB_REG, OPB_IMM, OPB_PCINCR, OPB_NONE} op_b_sel_e;
  typedef enum logic [1:0] {OPC_SEL_REG, OPC_SEL_BCH, OPC_SEL_NONE} op_c_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_U} imm_sel_e;

  // Forwarding source, driven by the controller
  typedef enum logic [1:0] {FW_RF, FW_EX, FW_WB} fw_sel_e;

endpackage
